/* source/xv_defs.svh */
// ##########################################################################
// raster timing is a tiny 16x4 visible frame so simulation stays short
// all timing values are in clocks (horizontal) or lines (vertical)
// counter widths must hold the totals below, check them if timing grows
// ##########################################################################
`ifndef XV_DEFS_SVH
`define XV_DEFS_SVH

// horizontal timing, clocks
`define XV_H_VISIBLE    16
`define XV_H_FRONT      2
`define XV_H_SYNC       2
`define XV_H_BACK       4
`define XV_H_TOTAL      (`XV_H_VISIBLE + `XV_H_FRONT + `XV_H_SYNC + `XV_H_BACK)
`define XV_H_CW         5           // h counter width, holds 0..23

// vertical timing, lines
`define XV_V_VISIBLE    4
`define XV_V_FRONT      1
`define XV_V_SYNC       1
`define XV_V_BACK       2
`define XV_V_TOTAL      (`XV_V_VISIBLE + `XV_V_FRONT + `XV_V_SYNC + `XV_V_BACK)
`define XV_V_CW         4           // v counter width, holds 0..7

// memories
`define XV_VRAM_WORDS   1024
`define XV_VRAM_AW      10
`define XV_PAL_ENTRIES  256
`define XV_REG_COUNT    10          // mapped APB registers, rest is slverr

`endif

/* source/xv_bus_pkg.sv */
// ##########################################################################
// CPU side types: APB port, VRAM request and register map
// paddr is a word address, only 16-bit accesses exist
// ##########################################################################
`default_nettype none

`include "xv_defs.svh"

package xv_bus_pkg;

typedef struct packed {
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [3:0]     paddr;          // word register number
    logic [15:0]    pwdata;
} apb_req_t;

typedef struct packed {
    logic [15:0]    prdata;
    logic           pready;
    logic           pslverr;
} apb_rsp_t;

typedef struct packed {
    logic                       sel;    // held until ack
    logic                       wr;
    logic [`XV_VRAM_AW-1:0]     addr;
    logic [15:0]                data;
} vram_req_t;

typedef enum logic [3:0] {
    REG_MODE        = 4'd0,     // bit 0 = 8 bpp
    REG_BASE        = 4'd1,     // frame start word
    REG_VADDR       = 4'd2,
    REG_VDATA       = 4'd3,     // post-increments VADDR
    REG_PADDR       = 4'd4,
    REG_PDATA       = 4'd5,     // write only, post-increments PADDR
    REG_INT_MASK    = 4'd6,
    REG_INT_STATUS  = 4'd7,     // write 1 to clear
    REG_LINE_CMP    = 4'd8,
    REG_STATUS      = 4'd9      // bit 0 vblank, bit 1 hblank
} reg_num_e;

typedef logic [1:0] intr_t;
localparam int INTR_VBLANK = 0;     // first blank line
localparam int INTR_LINE   = 1;     // line compare hit

endpackage

`default_nettype wire

/* source/xv_video_pkg.sv */
// ##########################################################################
// video side types, pipeline stage structs and the VRAM word decode
// pixel 0 of a VRAM word is always the most significant field
// ##########################################################################
`default_nettype none

package xv_video_pkg;

typedef logic [3:0] idx4_t;         // 4-bpp colour index
typedef logic [7:0] idx8_t;         // 8-bpp colour index, palette address

typedef struct packed {
    logic [3:0]     red;
    logic [3:0]     green;
    logic [3:0]     blue;
} rgb_t;

// one VRAM word seen as 4 nibble pixels or 2 byte pixels
// px4[3] / px8[1] is pixel 0
typedef union packed {
    idx4_t [3:0]    px4;
    idx8_t [1:0]    px8;
} vram_word_u;

// stage 1 -> stage 2
typedef struct packed {
    logic           de;
    logic           hsync;
    logic           vsync;
    logic           fetch;          // VRAM word arrives with this pixel
    logic [1:0]     sub;            // pixel number inside the word
} pix_req_t;

// stage 2 -> stage 3
typedef struct packed {
    logic           de;
    logic           hsync;
    logic           vsync;
    idx8_t          idx;            // 4-bpp indices zero extended
} pix_idx_t;

typedef struct packed {
    logic           hsync;
    logic           vsync;
    logic           de;
    rgb_t           rgb;
} video_out_t;

endpackage

`default_nettype wire

/* source/xv_reg_interface.sv */
// ##########################################################################
// APB slave with the mode, base, VRAM port, palette port and irq registers
// only REG_VDATA stalls (pready low until the VRAM arbiter acks)
// palette is write only, REG_PDATA reads as zero
// unmapped addresses finish at once with pslverr, reads return zero
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_reg_interface
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire apb_req_t                   apb_req_i,
    output apb_rsp_t                        apb_rsp_o,
    output vram_req_t                       vram_req_o,
    input  wire logic                       vram_ack_i,     // one cycle after grant
    input  wire logic [15:0]                vram_data_i,
    output logic                            mode_bpp8_o,
    output logic [`XV_VRAM_AW-1:0]          base_o,
    output logic [`XV_V_CW-1:0]             line_cmp_o,
    output logic                            pal_wr_o,
    output logic [7:0]                      pal_addr_o,
    output rgb_t                            pal_data_o,
    output intr_t                           intr_mask_o,
    output intr_t                           intr_clear_o,   // pulse, write 1 to clear
    input  wire intr_t                      intr_status_i,
    input  wire logic                       vblank_i,
    input  wire logic                       hblank_i
);

reg_num_e                   reg_num;
logic                       access;         // APB access phase
logic                       unmapped;
logic                       done;           // transfer ends this cycle
logic                       wr_done;
logic [`XV_VRAM_AW-1:0]     vaddr;          // VRAM pointer
logic [15:0]                rd_data;

always_comb begin
    reg_num  = reg_num_e'(apb_req_i.paddr);
    access   = apb_req_i.psel & apb_req_i.penable;
    unmapped = apb_req_i.paddr >= 4'(`XV_REG_COUNT);
    done     = access & ((reg_num != REG_VDATA) | vram_ack_i);   // vdata waits for ack
    wr_done  = done & apb_req_i.pwrite & ~unmapped;
end

// VRAM port, sel drops in the ack cycle so no second grant
always_comb begin
    vram_req_o.sel  = access & (reg_num == REG_VDATA) & ~vram_ack_i;
    vram_req_o.wr   = apb_req_i.pwrite;
    vram_req_o.addr = vaddr;
    vram_req_o.data = apb_req_i.pwdata;
end

assign pal_wr_o     = wr_done & (reg_num == REG_PDATA);
assign pal_data_o   = rgb_t'(apb_req_i.pwdata[11:0]);         // 0x0RGB
assign intr_clear_o = (wr_done && reg_num == REG_INT_STATUS) ?
                      intr_t'(apb_req_i.pwdata[1:0]) : '0;

always_comb begin
    case (reg_num)
        REG_MODE:       rd_data = {15'h0, mode_bpp8_o};
        REG_BASE:       rd_data = 16'(base_o);
        REG_VADDR:      rd_data = 16'(vaddr);
        REG_VDATA:      rd_data = vram_data_i;          // valid in ack cycle
        REG_PADDR:      rd_data = 16'(pal_addr_o);
        REG_INT_MASK:   rd_data = 16'(intr_mask_o);
        REG_INT_STATUS: rd_data = 16'(intr_status_i);
        REG_LINE_CMP:   rd_data = 16'(line_cmp_o);
        REG_STATUS:     rd_data = {14'h0, hblank_i, vblank_i};
        default:        rd_data = 16'h0;                // PDATA and unmapped
    endcase
end

always_comb begin
    apb_rsp_o.prdata  = rd_data;
    apb_rsp_o.pready  = done;
    apb_rsp_o.pslverr = access & unmapped;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        mode_bpp8_o <= 1'b0;
        base_o      <= '0;
        vaddr       <= '0;
        pal_addr_o  <= '0;
        intr_mask_o <= '0;
        line_cmp_o  <= '0;
    end else if (done) begin
        case (reg_num)
            REG_MODE:       if (apb_req_i.pwrite) mode_bpp8_o <= apb_req_i.pwdata[0];
            REG_BASE:       if (apb_req_i.pwrite) base_o <= apb_req_i.pwdata[`XV_VRAM_AW-1:0];
            REG_VADDR:      if (apb_req_i.pwrite) vaddr <= apb_req_i.pwdata[`XV_VRAM_AW-1:0];
            REG_VDATA:      vaddr <= vaddr + 1'b1;          // read or write
            REG_PADDR:      if (apb_req_i.pwrite) pal_addr_o <= apb_req_i.pwdata[7:0];
            REG_PDATA:      if (apb_req_i.pwrite) pal_addr_o <= pal_addr_o + 1'b1;
            REG_INT_MASK:   if (apb_req_i.pwrite) intr_mask_o <= apb_req_i.pwdata[1:0];
            REG_LINE_CMP:   if (apb_req_i.pwrite) line_cmp_o <= apb_req_i.pwdata[`XV_V_CW-1:0];
            default: ;
        endcase
    end
end

endmodule

`default_nettype wire

/* source/xv_vram_arb.sv */
// ##########################################################################
// single port VRAM, video fetch always wins the cycle
// CPU gets ack and read data one cycle after its grant, latency varies
// read data register is shared, video data follows a fetch by one cycle
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_vram_arb
    import xv_bus_pkg::*;
(
    input  wire logic                       clk,
    input  wire vram_req_t                  cpu_req_i,
    output logic                            cpu_ack_o,
    input  wire logic                       vid_sel_i,      // never waits
    input  wire logic [`XV_VRAM_AW-1:0]     vid_addr_i,
    output logic [15:0]                     rd_data_o
);

logic [15:0]                vram [`XV_VRAM_WORDS];
logic                       cpu_grant;
logic [`XV_VRAM_AW-1:0]     rd_addr;

always_comb begin
    cpu_grant = cpu_req_i.sel & ~vid_sel_i;                 // only when video is idle
    rd_addr   = vid_sel_i ? vid_addr_i : cpu_req_i.addr;
end

always_ff @(posedge clk) begin
    if (cpu_grant && cpu_req_i.wr) begin
        vram[cpu_req_i.addr] <= cpu_req_i.data;             // lands in grant cycle
    end
    rd_data_o <= vram[rd_addr];
    cpu_ack_o <= cpu_grant;                                 // reader drops sel on ack
end

endmodule

`default_nettype wire

/* source/xv_video_timing.sv */
// ##########################################################################
// stage 1: raster counters, sync, blank and VRAM fetch address
// fetch request is combinational from the counters, pix_o is registered,
// so VRAM data and the matching pix_o reach stage 2 together
// fetch address reloads from base_i throughout vblank
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_video_timing
    import xv_video_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       mode_bpp8_i,
    input  wire logic [`XV_VRAM_AW-1:0]     base_i,
    input  wire logic [`XV_V_CW-1:0]        line_cmp_i,
    output logic                            vid_sel_o,
    output logic [`XV_VRAM_AW-1:0]          vid_addr_o,
    output pix_req_t                        pix_o,
    output logic                            vblank_o,
    output logic                            hblank_o,
    output logic                            vblank_intr_o,
    output logic                            line_intr_o
);

logic [`XV_H_CW-1:0]        h_count;
logic [`XV_V_CW-1:0]        v_count;
logic [`XV_VRAM_AW-1:0]     fetch_addr;
logic                       h_vis, v_vis;
logic                       h_sync, v_sync;
logic [1:0]                 sub;            // pixel inside current word
logic                       word_end;       // last pixel of the word

always_comb begin
    h_vis    = h_count < `XV_H_VISIBLE;
    v_vis    = v_count < `XV_V_VISIBLE;
    h_sync   = (h_count >= `XV_H_VISIBLE + `XV_H_FRONT) &&
               (h_count <  `XV_H_VISIBLE + `XV_H_FRONT + `XV_H_SYNC);
    v_sync   = (v_count >= `XV_V_VISIBLE + `XV_V_FRONT) &&
               (v_count <  `XV_V_VISIBLE + `XV_V_FRONT + `XV_V_SYNC);
    sub      = mode_bpp8_i ? {1'b0, h_count[0]} : h_count[1:0];
    word_end = mode_bpp8_i ? h_count[0] : &h_count[1:0];

    vid_sel_o  = h_vis & v_vis & (sub == 2'd0);     // first pixel of each word
    vid_addr_o = fetch_addr;

    vblank_o      = ~v_vis;
    hblank_o      = ~h_vis;
    vblank_intr_o = (v_count == `XV_V_VISIBLE) && (h_count == '0);
    line_intr_o   = (v_count == line_cmp_i) && (h_count == '0);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count    <= '0;
        v_count    <= '0;
        fetch_addr <= '0;
        pix_o      <= '0;
    end else begin
        if (h_count == `XV_H_TOTAL - 1) begin
            h_count <= '0;
            v_count <= (v_count == `XV_V_TOTAL - 1) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end

        if (!v_vis) begin
            fetch_addr <= base_i;
        end else if (h_vis && word_end) begin
            fetch_addr <= fetch_addr + 1'b1;        // lines are contiguous
        end

        pix_o.de    <= h_vis & v_vis;
        pix_o.hsync <= h_sync;
        pix_o.vsync <= v_sync;
        pix_o.fetch <= vid_sel_o;
        pix_o.sub   <= sub;
    end
end

endmodule

`default_nettype wire

/* source/xv_pixel_fetch.sv */
// ##########################################################################
// stage 2: hold the fetched VRAM word and pick one colour index per pixel
// vram_data_i is only valid in the cycle pix_i.fetch is set
// mode must not change mid word or the index is mixed
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

module xv_pixel_fetch
    import xv_video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           mode_bpp8_i,
    input  wire pix_req_t       pix_i,
    input  wire logic [15:0]    vram_data_i,
    output pix_idx_t            idx_o
);

vram_word_u     word_q;         // word of the current pixel group
vram_word_u     word_cur;
idx8_t          idx;

always_comb begin
    word_cur = pix_i.fetch ? vram_word_u'(vram_data_i) : word_q;
    // pixel 0 sits in the top field, so invert the sub number
    if (mode_bpp8_i) begin
        idx = word_cur.px8[~pix_i.sub[0]];
    end else begin
        idx = {4'h0, word_cur.px4[~pix_i.sub]};
    end
end

always_ff @(posedge clk) begin
    if (pix_i.fetch) begin
        word_q <= vram_word_u'(vram_data_i);
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        idx_o <= '0;
    end else begin
        idx_o.de    <= pix_i.de;
        idx_o.hsync <= pix_i.hsync;
        idx_o.vsync <= pix_i.vsync;
        idx_o.idx   <= idx;
    end
end

endmodule

`default_nettype wire

/* source/xv_color_lut.sv */
// ##########################################################################
// stage 3: palette RAM and registered RGB out, syncs travel alongside
// rgb is forced to zero outside the display area
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_color_lut
    import xv_video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           pal_wr_i,
    input  wire logic [7:0]     pal_addr_i,
    input  wire rgb_t           pal_data_i,
    input  wire pix_idx_t       idx_i,
    output video_out_t          video_o
);

rgb_t       palette [`XV_PAL_ENTRIES];

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        palette[pal_addr_i] <= pal_data_i;      // CPU side only writes
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        video_o <= '0;
    end else begin
        video_o.hsync <= idx_i.hsync;
        video_o.vsync <= idx_i.vsync;
        video_o.de    <= idx_i.de;
        video_o.rgb   <= idx_i.de ? palette[idx_i.idx] : '0;   // black in blank
    end
end

endmodule

`default_nettype wire

/* source/xv_main.sv */
// ##########################################################################
// bitmap video controller top, APB registers plus 3 stage video pipeline
// video_o lags the raster counters by 3 clocks, syncs are active high
// irq_o is registered, rises one clock after masked status goes pending
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_main
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire apb_req_t   apb_req_i,
    output apb_rsp_t        apb_rsp_o,
    output video_out_t      video_o,
    output logic            irq_o
);

vram_req_t                  regs_vram_req;
logic                       regs_vram_ack;
logic [15:0]                vram_rd_data;       // shared by CPU and video
logic                       vid_sel;
logic [`XV_VRAM_AW-1:0]     vid_addr;

logic                       mode_bpp8;
logic [`XV_VRAM_AW-1:0]     base;
logic [`XV_V_CW-1:0]        line_cmp;
logic                       pal_wr;
logic [7:0]                 pal_addr;
rgb_t                       pal_data;

logic                       vblank, hblank;
logic                       vblank_intr, line_intr;
intr_t                      intr_trigger, intr_mask, intr_clear, intr_status;

pix_req_t                   pix_req;            // stage 1 -> 2
pix_idx_t                   pix_idx;            // stage 2 -> 3

xv_reg_interface reg_interface (
    .clk(clk), .reset_i(reset_i),
    .apb_req_i(apb_req_i), .apb_rsp_o(apb_rsp_o),
    .vram_req_o(regs_vram_req), .vram_ack_i(regs_vram_ack), .vram_data_i(vram_rd_data),
    .mode_bpp8_o(mode_bpp8), .base_o(base), .line_cmp_o(line_cmp),
    .pal_wr_o(pal_wr), .pal_addr_o(pal_addr), .pal_data_o(pal_data),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .intr_status_i(intr_status),
    .vblank_i(vblank), .hblank_i(hblank)
);

xv_vram_arb vram_arb (
    .clk(clk),
    .cpu_req_i(regs_vram_req), .cpu_ack_o(regs_vram_ack),
    .vid_sel_i(vid_sel), .vid_addr_i(vid_addr),
    .rd_data_o(vram_rd_data)
);

xv_video_timing video_timing (
    .clk(clk), .reset_i(reset_i),
    .mode_bpp8_i(mode_bpp8), .base_i(base), .line_cmp_i(line_cmp),
    .vid_sel_o(vid_sel), .vid_addr_o(vid_addr), .pix_o(pix_req),
    .vblank_o(vblank), .hblank_o(hblank),
    .vblank_intr_o(vblank_intr), .line_intr_o(line_intr)
);

xv_pixel_fetch pixel_fetch (
    .clk(clk), .reset_i(reset_i), .mode_bpp8_i(mode_bpp8),
    .pix_i(pix_req), .vram_data_i(vram_rd_data), .idx_o(pix_idx)
);

xv_color_lut color_lut (
    .clk(clk), .reset_i(reset_i),
    .pal_wr_i(pal_wr), .pal_addr_i(pal_addr), .pal_data_i(pal_data),
    .idx_i(pix_idx), .video_o(video_o)
);

always_comb begin
    intr_trigger              = '0;
    intr_trigger[INTR_VBLANK] = vblank_intr;
    intr_trigger[INTR_LINE]   = line_intr;
end

// pending status, a new trigger beats a clear in the same cycle
always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status <= '0;
        irq_o       <= 1'b0;
    end else begin
        intr_status <= (intr_status & ~intr_clear) | intr_trigger;
        irq_o       <= |(intr_status & intr_mask);
    end
end

endmodule

`default_nettype wire

/* verif/xv_main_properties.sv */
// ##########################################################################
// concurrent checks on the xv_main ports, attached by bind
// hsync width comes from the timing macros, syncs are active high
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_main_properties
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire apb_req_t       apb_req_i,
    input  wire apb_rsp_t       apb_rsp_i,
    input  wire video_out_t     video_i,
    input  wire logic           irq_i
);

rgb_black: assert property (@(posedge clk) disable iff (reset_i)
    !video_i.de |-> video_i.rgb == '0)
    else $error("rgb not black outside the display area");

pready_in_access: assert property (@(posedge clk) disable iff (reset_i)
    apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable)
    else $error("pready high outside an APB access phase");

hsync_width: assert property (@(posedge clk) disable iff (reset_i)
    $rose(video_i.hsync) |-> video_i.hsync [*`XV_H_SYNC] ##1 !video_i.hsync)
    else $error("hsync pulse width differs from the timing macro");

irq_low_after_reset: assert property (@(posedge clk)
    reset_i |=> !irq_i)
    else $error("irq_o high right after reset");

endmodule

bind xv_main xv_main_properties props (
    .clk(clk), .reset_i(reset_i),
    .apb_req_i(apb_req_i), .apb_rsp_i(apb_rsp_o),
    .video_i(video_o), .irq_i(irq_o)
);

`default_nettype wire

/* verif/xv_main_tb.sv */
// ##########################################################################
// directed testbench for the bitmap video controller, five tests
// APB inputs change 1 ns after the rising edge, outputs sampled at negedge
// a frame capture aligns on the rising edge of vsync at the DUT output
// palette and VRAM are mirrored in tb arrays to predict every pixel
// ##########################################################################
`default_nettype none
`timescale 1ns/100ps

`include "xv_defs.svh"

module xv_main_tb
    import xv_bus_pkg::*, xv_video_pkg::*;
;

localparam int FRAME_CYCLES = `XV_H_TOTAL * `XV_V_TOTAL;    // 192 clocks
localparam int FRAMES_USED  = 8;
localparam int APB_ACCESSES = 600;      // rough sum over all tests
localparam int APB_CYCLES   = 5;        // idle, setup, access, stall
localparam int TIMEOUT_NS   = (FRAMES_USED * FRAME_CYCLES + APB_ACCESSES * APB_CYCLES) * 8 * 4;
localparam int PIXELS       = `XV_H_VISIBLE * `XV_V_VISIBLE;

logic               clk;
logic               reset_i;
apb_req_t           apb_req;
apb_rsp_t           apb_rsp;
video_out_t         video;
logic               irq;

logic [15:0]        vram_model [`XV_VRAM_WORDS];
rgb_t               pal_model [`XV_PAL_ENTRIES];
rgb_t               frame_pix [PIXELS];             // by de count, raster order
int                 de_count, hsync_count;
int                 errors, tests_run, tests_failed;

xv_main UUT (
    .clk(clk), .reset_i(reset_i),
    .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
    .video_o(video), .irq_o(irq)
);

always #4 clk = ~clk;           // 8 ns period

initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the tests did not finish in %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
end

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got);
        errors++;
    end
endtask

// one APB transfer, waits on pready with a bound
task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata, output logic slverr);
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;                 // setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;                 // access phase
    @(negedge clk);
    while (!apb_rsp.pready && waits < 50) begin
        @(negedge clk);
        waits++;
    end
    if (!apb_rsp.pready) begin
        $display("APB transfer to register %0d never completed", addr);
        errors++;
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);                         // transfer ends on this edge
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [15:0] wdata);
    logic [15:0] unused_rd;
    logic        err;
    apb_access(1'b1, addr, wdata, unused_rd, err);
    check_value("pslverr", 16'(err), 16'h0000);             // mapped register
endtask

task automatic apb_read(input logic [3:0] addr, output logic [15:0] rdata);
    logic err;
    apb_access(1'b0, addr, 16'h0, rdata, err);
    check_value("pslverr", 16'(err), 16'h0000);             // mapped register
endtask

// one full frame, from a vsync rise to the next one
task automatic capture_frame(output bit ok);
    int   cycles;
    logic hs_prev;
    logic vs_prev;
    ok          = 1'b1;
    de_count    = 0;
    hsync_count = 0;
    cycles      = 0;
    @(negedge clk);
    while (video.vsync && cycles < 2 * FRAME_CYCLES) begin    // leave a running vsync
        @(negedge clk);
        cycles++;
    end
    while (!video.vsync && cycles < 2 * FRAME_CYCLES) begin
        @(negedge clk);
        cycles++;
    end
    if (!video.vsync) begin
        ok = 1'b0;
        return;
    end
    hs_prev = 1'b0;
    vs_prev = 1'b0;
    cycles  = 0;
    do begin
        if (video.de) begin
            if (de_count < PIXELS) frame_pix[de_count] = video.rgb;
            de_count++;
        end
        if (video.hsync && !hs_prev) hsync_count++;
        hs_prev = video.hsync;
        vs_prev = video.vsync;
        @(negedge clk);
        cycles++;
    end while (!(video.vsync && !vs_prev) && cycles < 2 * FRAME_CYCLES);
    if (cycles >= 2 * FRAME_CYCLES) ok = 1'b0;
endtask

// expected pixel from the VRAM and palette mirrors, pixel 0 in the top field
task automatic check_frame(input bit bpp8, input logic [`XV_VRAM_AW-1:0] base);
    int                      x, y;
    logic [`XV_VRAM_AW-1:0]  addr;
    logic [7:0]              idx;
    for (int k = 0; k < PIXELS; k++) begin
        x = k % `XV_H_VISIBLE;
        y = k / `XV_H_VISIBLE;
        if (bpp8) begin
            addr = base + `XV_VRAM_AW'(y * (`XV_H_VISIBLE / 2) + x / 2);
            idx  = (x % 2 == 0) ? vram_model[addr][15:8] : vram_model[addr][7:0];
        end else begin
            addr = base + `XV_VRAM_AW'(y * (`XV_H_VISIBLE / 4) + x / 4);
            idx  = 8'((vram_model[addr] >> (12 - 4 * (x % 4))) & 16'h000f);
        end
        check_value($sformatf("rgb at (%0d,%0d)", x, y), 16'(frame_pix[k]),
                    16'(pal_model[idx]));
    end
    check_value("de count per frame", 16'(de_count), 16'(PIXELS));
    check_value("hsync pulses per frame", 16'(hsync_count), 16'(`XV_V_TOTAL));
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
        $display("test %-10s ok", name);
    end else begin
        tests_failed++;
        $display("test %-10s failed with %0d errors", name, errors - errors_before);
    end
endtask

task automatic test_registers();
    int          e0;
    logic [15:0] wr_val, rd;
    logic        err;
    e0 = errors;
    apb_write(REG_MODE, 16'h0001);
    apb_read(REG_MODE, rd);
    check_value("prdata REG_MODE", rd, 16'h0001);
    wr_val = 16'(10'($urandom));
    apb_write(REG_BASE, wr_val);
    apb_read(REG_BASE, rd);
    check_value("prdata REG_BASE", rd, wr_val);
    wr_val = 16'(4'($urandom));
    apb_write(REG_LINE_CMP, wr_val);
    apb_read(REG_LINE_CMP, rd);
    check_value("prdata REG_LINE_CMP", rd, wr_val);
    wr_val = 16'(2'($urandom));
    apb_write(REG_INT_MASK, wr_val);
    apb_read(REG_INT_MASK, rd);
    check_value("prdata REG_INT_MASK", rd, wr_val);
    apb_access(1'b1, 4'd12, 16'hbeef, rd, err);             // unmapped write
    if (!err) begin
        $display("write to unmapped address 12 completed without pslverr");
        errors++;
    end
    apb_access(1'b0, 4'd12, 16'h0, rd, err);
    if (!err) begin
        $display("read of unmapped address 12 completed without pslverr");
        errors++;
    end
    check_value("prdata unmapped", rd, 16'h0000);
    apb_write(REG_MODE, 16'h0000);
    apb_write(REG_INT_MASK, 16'h0000);
    finish_test("registers", e0);
endtask

task automatic test_vram();
    int                      e0;
    logic [`XV_VRAM_AW-1:0]  start, addr;
    logic [15:0]             data, rd;
    e0    = errors;
    start = `XV_VRAM_AW'($urandom);
    apb_write(REG_VADDR, 16'(start));
    for (int i = 0; i < 32; i++) begin
        addr             = start + `XV_VRAM_AW'(i);
        data             = 16'($urandom);
        vram_model[addr] = data;
        apb_write(REG_VDATA, data);                         // stalls behind video fetch
    end
    apb_read(REG_VADDR, rd);
    check_value("prdata REG_VADDR", rd, 16'(start + `XV_VRAM_AW'(32)));
    apb_write(REG_VADDR, 16'(start));
    for (int i = 0; i < 32; i++) begin
        addr = start + `XV_VRAM_AW'(i);
        apb_read(REG_VDATA, rd);
        check_value($sformatf("prdata vram[%0h]", addr), rd, vram_model[addr]);
    end
    finish_test("vram", e0);
endtask

// loads palette and frame, then captures and checks one frame
task automatic test_frame(input bit bpp8, input logic [`XV_VRAM_AW-1:0] base, input string name);
    int                      e0, colours, words;
    rgb_t                    col;
    logic [`XV_VRAM_AW-1:0]  addr;
    logic [15:0]             data;
    bit                      ok;
    e0      = errors;
    colours = bpp8 ? 256 : 16;
    words   = bpp8 ? PIXELS / 2 : PIXELS / 4;
    apb_write(REG_MODE, 16'(bpp8));
    apb_write(REG_BASE, 16'(base));
    apb_write(REG_PADDR, 16'h0000);
    for (int i = 0; i < colours; i++) begin
        col          = rgb_t'($urandom);
        pal_model[i] = col;
        apb_write(REG_PDATA, 16'(col));                     // 0x0RGB
    end
    apb_write(REG_VADDR, 16'(base));
    for (int i = 0; i < words; i++) begin
        addr             = base + `XV_VRAM_AW'(i);
        data             = 16'($urandom);
        vram_model[addr] = data;
        apb_write(REG_VDATA, data);
    end
    capture_frame(ok);
    if (!ok) begin
        $display("no complete frame seen at the video output");
        errors++;
    end else begin
        check_frame(bpp8, base);
    end
    finish_test(name, e0);
endtask

task automatic test_interrupts();
    int          e0, cycles, polls;
    logic [15:0] rd;
    logic        irq_seen;
    e0 = errors;
    apb_write(REG_INT_MASK, 16'h0000);
    apb_write(REG_INT_STATUS, 16'h0003);                    // drop anything pending
    apb_write(REG_INT_MASK, 16'h0001);                      // vblank only
    cycles = 0;
    @(negedge clk);
    while (!irq && cycles < 2 * FRAME_CYCLES) begin
        @(negedge clk);
        cycles++;
    end
    if (!irq) begin
        $display("irq_o never rose for the vblank interrupt");
        errors++;
    end else begin
        apb_read(REG_STATUS, rd);                           // still inside vblank
        check_value("REG_STATUS vblank bit", 16'(rd[0]), 16'h0001);
        apb_read(REG_INT_STATUS, rd);
        check_value("REG_INT_STATUS vblank bit", 16'(rd[0]), 16'h0001);
        apb_write(REG_INT_STATUS, 16'h0003);
        @(posedge clk);                                     // irq_o is one clock behind
        @(negedge clk);
        check_value("irq_o after clear", 16'(irq), 16'h0000);
        apb_read(REG_INT_STATUS, rd);
        check_value("REG_INT_STATUS vblank bit after clear", 16'(rd[0]), 16'h0000);
    end
    // line compare with every source masked
    apb_write(REG_INT_MASK, 16'h0000);
    apb_write(REG_LINE_CMP, 16'h0002);
    apb_write(REG_INT_STATUS, 16'h0003);
    rd       = 16'h0;
    polls    = 0;
    irq_seen = 1'b0;
    while (!rd[1] && polls < 100) begin
        apb_read(REG_INT_STATUS, rd);
        if (irq !== 1'b0) irq_seen = 1'b1;
        polls++;
    end
    if (!rd[1]) begin
        $display("line compare status bit never set");
        errors++;
    end
    @(negedge clk);
    if (irq !== 1'b0) irq_seen = 1'b1;
    check_value("irq_o with line compare masked", 16'(irq_seen), 16'h0000);
    finish_test("interrupts", e0);
endtask

initial begin
    void'($urandom(32'h4fbc));
    clk          = 1'b0;
    reset_i      = 1'b1;
    apb_req      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;

    test_registers();
    test_vram();
    test_frame(1'b0, '0, "bpp4");
    test_frame(1'b1, `XV_VRAM_AW'($urandom), "bpp8");
    test_interrupts();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/xv_bus_pkg.sv
source/xv_video_pkg.sv
source/xv_reg_interface.sv
source/xv_vram_arb.sv
source/xv_video_timing.sv
source/xv_pixel_fetch.sv
source/xv_color_lut.sv
source/xv_main.sv
verif/xv_main_properties.sv
verif/xv_main_tb.sv
